// ==== dcache.f ====
+incdir+include
logic/mem_access_pkg.sv
logic/cache_line_pkg.sv
logic/ram_bus_if.sv
logic/dcache.sv
logic/data_ram.sv
logic/dcache_subsystem.sv
verif/dcache_tb.sv

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache_tb;

    import mem_access_pkg::*;
    import cache_line_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int TAGS_PER_INDEX = 3;
    localparam int CACHED_WORDS   = 24;
    localparam int POOL_WORDS     = 28;
    localparam int RANDOM_OPS     = 400;

    logic         clock;
    logic         reset;
    logic         read_i;
    logic         write_i;
    access_size_t size_i;
    logic         signed_i;
    addr_t        addr_i;
    word_t        wdata_i;
    logic         ready_o;
    word_t        rdata_o;

    logic [31:0] lcg_state;
    // Reference memory with one entry per byte address
    logic [7:0]  model_mem [int];
    // Word addresses used by the test with the cached ones first
    addr_t       pool [POOL_WORDS];

    dcache_subsystem dcache_subsystem_i (
        .clock    (clock),
        .reset    (reset),
        .read_i   (read_i),
        .write_i  (write_i),
        .size_i   (size_i),
        .signed_i (signed_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .ready_o  (ready_o),
        .rdata_o  (rdata_o)
    );

    always #10 clock = ~clock;

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic access_size_t pick_size(input logic [31:0] r);
        case (r % 3)
            0:       return BYTE;
            1:       return HALF;
            default: return WORD;
        endcase
    endfunction

    // Aligned byte address inside the given word
    function automatic addr_t offset_addr(input addr_t base, input access_size_t size,
                                          input logic [31:0] r);
        case (size)
            BYTE:    return base | addr_t'(r[1:0]);
            HALF:    return base | addr_t'({r[1], 1'b0});
            default: return base;
        endcase
    endfunction

    // Little endian with store data taken from the low bytes
    function automatic void model_write(input addr_t addr, input access_size_t size,
                                        input word_t wdata);
        for (int j = 0; j < int'(size); j++) begin
            model_mem[int'(addr) + j] = wdata[8*j +: 8];
        end
    endfunction

    function automatic word_t model_read(input addr_t addr, input access_size_t size,
                                         input logic sgn);
        word_t value;
        value = '0;
        for (int j = 0; j < int'(size); j++) begin
            value[8*j +: 8] = model_mem[int'(addr) + j];
        end
        if (sgn && size == BYTE) begin
            value[31:8] = {24{value[7]}};
        end else if (sgn && size == HALF) begin
            value[31:16] = {16{value[15]}};
        end
        return value;
    endfunction

    task automatic abort_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            abort_run();
        end
    endtask

    // --------------------
    // Requests
    // --------------------

    // Starts at 2 ns after an edge and returns at the same point after ready_o
    task automatic run_request(input logic is_write, input access_size_t size,
                               input logic sgn, input addr_t addr, input word_t wdata,
                               output word_t rdata, output int wait_cycles);
        logic done;
        done        = 1'b0;
        wait_cycles = 0;
        rdata       = '0;
        read_i      = !is_write;
        write_i     = is_write;
        size_i      = size;
        signed_i    = sgn;
        addr_i      = addr;
        wdata_i     = wdata;
        while (!done) begin
            @(negedge clock);
            if (ready_o) begin
                done  = 1'b1;
                rdata = rdata_o;
            end else begin
                wait_cycles++;
                if (wait_cycles >= TIMEOUT_CYCLES) begin
                    $display("Request to address 0x%h got no ready_o within %0d cycles",
                             addr, TIMEOUT_CYCLES);
                    abort_run();
                end
            end
        end
        @(posedge clock);
        #2;
        read_i  = 1'b0;
        write_i = 1'b0;
    endtask

    task automatic store(input access_size_t size, input addr_t addr, input word_t wdata);
        word_t rdata;
        int    cycles;
        run_request(1'b1, size, 1'b0, addr, wdata, rdata, cycles);
        model_write(addr, size, wdata);
    endtask

    task automatic load_check(input access_size_t size, input logic sgn, input addr_t addr,
                              output int cycles);
        word_t rdata;
        run_request(1'b0, size, sgn, addr, '0, rdata, cycles);
        check_word("rdata_o", rdata, model_read(addr, size, sgn));
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        word_t        rdata;
        int           cycles;
        logic [31:0]  r;
        access_size_t size;
        addr_t        addr;

        clock     = 1'b0;
        reset     = 1'b1;
        read_i    = 1'b0;
        write_i   = 1'b0;
        size_i    = WORD;
        signed_i  = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        lcg_state = 32'hfe18fe4d;

        // Three conflicting tags on each of eight indices and four I/O words
        for (int i = 0; i < CACHED_WORDS / TAGS_PER_INDEX; i++) begin
            pool[i*3]     = {10'h015, index_t'(i * 9 + 3), 2'b00};
            pool[i*3 + 1] = {10'h0c2, index_t'(i * 9 + 3), 2'b00};
            pool[i*3 + 2] = {10'h1f7, index_t'(i * 9 + 3), 2'b00};
        end
        for (int u = 0; u < POOL_WORDS - CACHED_WORDS; u++) begin
            pool[CACHED_WORDS + u] = addr_t'(32'h2_0000 + u * 32'h124);
        end

        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;

        // Idle after reset before first reads that miss
        @(negedge clock);
        check_bit("ready_o", ready_o, 1'b0);
        @(posedge clock);
        #2;
        run_request(1'b0, WORD, 1'b0, pool[0], '0, rdata, cycles);
        check_bit("ready_o in request cycle", cycles == 0, 1'b0);
        run_request(1'b0, WORD, 1'b0, pool[3], '0, rdata, cycles);
        check_bit("ready_o in request cycle", cycles == 0, 1'b0);

        // Known contents everywhere before any checked read
        for (int k = 0; k < POOL_WORDS; k++) begin
            store(WORD, pool[k], next_random());
        end

        // Dirty eviction across the three tags of one index
        for (int t = 0; t < TAGS_PER_INDEX; t++) begin
            store(WORD, pool[t], next_random());
        end
        for (int t = 0; t < TAGS_PER_INDEX; t++) begin
            load_check(WORD, 1'b0, pool[t], cycles);
        end

        // Sub-word write-through on misses followed by a merge into a resident line
        store(BYTE, pool[12] | addr_t'(1), next_random());
        store(HALF, pool[13] | addr_t'(2), next_random());
        load_check(WORD, 1'b0, pool[12], cycles);
        store(BYTE, pool[12] | addr_t'(3), next_random());
        load_check(WORD, 1'b0, pool[12], cycles);
        load_check(WORD, 1'b0, pool[13], cycles);

        // Hit latency and uncached bypass
        load_check(WORD, 1'b0, pool[6], cycles);
        load_check(WORD, 1'b0, pool[6], cycles);
        check_bit("ready_o in request cycle", cycles == 0, 1'b1);
        store(WORD, pool[9], next_random());
        load_check(WORD, 1'b0, pool[9], cycles);
        check_bit("ready_o in request cycle", cycles == 0, 1'b1);
        load_check(WORD, 1'b0, pool[24], cycles);
        load_check(WORD, 1'b0, pool[24], cycles);
        check_bit("uncached latency reached", cycles >= `DCACHE_RAM_LATENCY, 1'b1);

        // Random mix of sizes, signs and addresses
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r    = next_random();
            size = pick_size(next_random());
            addr = offset_addr(pool[next_random() % POOL_WORDS], size, next_random());
            if (r[4]) begin
                store(size, addr, next_random());
            end else begin
                load_check(size, r[9], addr, cycles);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/dcache_subsystem.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_subsystem (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                read_i,
    input  wire                                write_i,
    input  wire mem_access_pkg::access_size_t  size_i,
    input  wire                                signed_i,
    input  wire mem_access_pkg::addr_t         addr_i,
    input  wire mem_access_pkg::word_t         wdata_i,
    output wire                                ready_o,
    output wire mem_access_pkg::word_t         rdata_o
);

    // Cache to backing RAM
    ram_bus_if ram_bus ();

    dcache u_dcache (
        .clock    (clock),
        .reset    (reset),
        .read_i   (read_i),
        .write_i  (write_i),
        .size_i   (size_i),
        .signed_i (signed_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .ready_o  (ready_o),
        .rdata_o  (rdata_o),
        .ram      (ram_bus.cache)
    );

    data_ram u_data_ram (
        .clock (clock),
        .reset (reset),
        .bus   (ram_bus.ram)
    );

endmodule

`default_nettype wire

// ==== logic/data_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module data_ram (
    input wire     clock,
    input wire     reset,
    ram_bus_if.ram bus
);

    import mem_access_pkg::*;
    import cache_line_pkg::*;

    localparam int COUNT_BITS = $clog2(`DCACHE_RAM_LATENCY);

    word_view_u mem [`DCACHE_RAM_WORDS];

    logic [COUNT_BITS-1:0] count;
    logic                  accept;
    logic                  finish;

    // Latched request
    logic                        op_write;
    addr_t                       op_addr;
    access_size_t                op_size;
    logic                        op_signed;
    word_t                       op_wdata;
    logic [`DCACHE_ADDR_BITS-3:0] op_word;

    assign op_word = op_addr[`DCACHE_ADDR_BITS-1:2];

    // Strobes are ignored while a transaction is running
    assign accept = !bus.busy && (bus.read || bus.write);
    assign finish = bus.busy && count == COUNT_BITS'(1);

    // --------------------
    // Timing
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            bus.busy  <= 1'b0;
            bus.ready <= 1'b0;
            count     <= '0;
        end else begin
            bus.ready <= 1'b0;
            if (bus.busy) begin
                count <= count - COUNT_BITS'(1);
                if (finish) begin
                    bus.busy  <= 1'b0;
                    bus.ready <= 1'b1;
                end
            end else if (accept) begin
                bus.busy <= 1'b1;
                count    <= COUNT_BITS'(`DCACHE_RAM_LATENCY - 1);
            end
        end
    end

    // --------------------
    // Data path
    // --------------------

    always_ff @(posedge clock) begin
        if (accept) begin
            op_write  <= bus.write;
            op_addr   <= bus.addr;
            op_size   <= bus.size;
            op_signed <= bus.is_signed;
            op_wdata  <= bus.wdata;
        end
        // Access happens as ready is raised
        if (finish) begin
            if (op_write) begin
                mem[op_word] <= lane_write(mem[op_word], op_size, op_addr[1:0], op_wdata);
            end else begin
                bus.rdata <= lane_read(mem[op_word], op_size, op_addr[1:0], op_signed);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "dcache_defines.svh"

module dcache (
    input  wire                                clock,
    input  wire                                reset,
    input  wire                                read_i,
    input  wire                                write_i,
    input  wire mem_access_pkg::access_size_t  size_i,
    input  wire                                signed_i,
    input  wire mem_access_pkg::addr_t         addr_i,
    input  wire mem_access_pkg::word_t         wdata_i,
    output logic                               ready_o,
    output mem_access_pkg::word_t              rdata_o,
    ram_bus_if.cache                           ram
);

    import mem_access_pkg::*;
    import cache_line_pkg::*;

    localparam int LINES = 1 << `DCACHE_INDEX_BITS;

    // What the pending RAM transaction is for
    typedef enum logic [2:0] {
        OP_NONE,
        OP_FILL,
        OP_READ,
        OP_WRITE,
        OP_WBACK
    } ram_op_t;

    // --------------------
    // Line storage
    // --------------------

    logic [LINES-1:0] line_valid;
    logic [LINES-1:0] line_dirty;
    tag_t             line_tag [LINES];
    word_view_u       line_data [LINES];

    // --------------------
    // Request decode
    // --------------------

    index_t     req_index;
    tag_t       req_tag;
    logic [1:0] req_offset;
    logic       cacheable;
    logic       line_hit;
    logic       victim_dirty;

    assign req_offset = addr_i[1:0];
    assign req_index  = addr_i[`DCACHE_INDEX_BITS+1:2];
    assign req_tag    = addr_i[`DCACHE_ADDR_BITS-1:`DCACHE_INDEX_BITS+2];
    assign cacheable  = !addr_i[`DCACHE_UNCACHED_BIT];

    assign line_hit = cacheable && line_valid[req_index]
                      && line_tag[req_index] == req_tag;

    // Line holds modified data of another address
    assign victim_dirty = line_dirty[req_index] && line_tag[req_index] != req_tag;

    ram_op_t next_op;
    ram_op_t pend_op;
    logic    waiting;
    logic    local_write;
    logic    issue;
    logic    fill_done;
    logic    wback_done;

    always_comb begin
        ready_o     = 1'b0;
        rdata_o     = '0;
        next_op     = OP_NONE;
        local_write = 1'b0;
        if (waiting) begin
            // A write-back alone does not finish the request
            if (ram.ready && pend_op != OP_WBACK) begin
                ready_o = 1'b1;
                rdata_o = ram.rdata;
            end
        end else if (read_i) begin
            if (line_hit) begin
                ready_o = 1'b1;
                rdata_o = lane_read(line_data[req_index], size_i, req_offset, signed_i);
            end else if (!cacheable || size_i != WORD) begin
                next_op = OP_READ;
            end else if (victim_dirty) begin
                next_op = OP_WBACK;
            end else begin
                next_op = OP_FILL;
            end
        end else if (write_i) begin
            if (!cacheable) begin
                next_op = OP_WRITE;
            end else if (size_i != WORD) begin
                // Sub-word stores only merge into a line that is present
                if (line_hit) begin
                    ready_o     = 1'b1;
                    local_write = 1'b1;
                end else begin
                    next_op = OP_WRITE;
                end
            end else if (victim_dirty) begin
                next_op = OP_WBACK;
            end else begin
                ready_o     = 1'b1;
                local_write = 1'b1;
            end
        end
    end

    assign issue      = next_op != OP_NONE && !ram.busy;
    assign fill_done  = waiting && ram.ready && pend_op == OP_FILL;
    assign wback_done = waiting && ram.ready && pend_op == OP_WBACK;

    // --------------------
    // RAM request
    // --------------------

    // Strobes go out for one cycle only in the cycle after the decision
    always_ff @(posedge clock) begin
        if (reset) begin
            waiting   <= 1'b0;
            pend_op   <= OP_NONE;
            ram.read  <= 1'b0;
            ram.write <= 1'b0;
        end else begin
            ram.read  <= 1'b0;
            ram.write <= 1'b0;
            if (waiting && ram.ready) begin
                waiting <= 1'b0;
            end else if (issue) begin
                waiting   <= 1'b1;
                pend_op   <= next_op;
                ram.read  <= next_op == OP_FILL || next_op == OP_READ;
                ram.write <= next_op == OP_WRITE || next_op == OP_WBACK;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            ram.is_signed <= signed_i;
            if (next_op == OP_WBACK) begin
                // Victim address rebuilt from the stored tag
                ram.addr  <= {line_tag[req_index], req_index, 2'b00};
                ram.size  <= WORD;
                ram.wdata <= line_data[req_index];
            end else begin
                ram.addr  <= addr_i;
                ram.size  <= size_i;
                ram.wdata <= wdata_i;
            end
        end
    end

    // --------------------
    // Line update
    // --------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_dirty <= '0;
        end else if (local_write) begin
            line_dirty[req_index] <= 1'b1;
            if (size_i == WORD) begin
                line_valid[req_index] <= 1'b1;
            end
        end else if (fill_done) begin
            line_valid[req_index] <= 1'b1;
            line_dirty[req_index] <= 1'b0;
        end else if (wback_done) begin
            line_dirty[req_index] <= 1'b0;
        end
    end

    // Word stores take the whole line, so no fetch is needed
    always_ff @(posedge clock) begin
        if (local_write) begin
            line_data[req_index] <= lane_write(line_data[req_index], size_i,
                                               req_offset, wdata_i);
            if (size_i == WORD) begin
                line_tag[req_index] <= req_tag;
            end
        end else if (fill_done) begin
            line_data[req_index] <= ram.rdata;
            line_tag[req_index]  <= req_tag;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ram_bus_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface ram_bus_if;

    import mem_access_pkg::*;

    // Request driven by the cache
    logic         read;
    logic         write;
    access_size_t size;
    logic         is_signed;
    addr_t        addr;
    word_t        wdata;

    // Response driven by the RAM
    logic  busy;
    logic  ready;
    word_t rdata;

    modport cache (
        output read, write, size, is_signed, addr, wdata,
        input  busy, ready, rdata
    );

    modport ram (
        input  read, write, size, is_signed, addr, wdata,
        output busy, ready, rdata
    );

endinterface

`default_nettype wire

// ==== logic/cache_line_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package cache_line_pkg;

    import mem_access_pkg::*;

    // --------------------
    // Line organization
    // --------------------

    // Index sits right above the two byte offset bits
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;

    // Everything above the index including the uncached bit
    typedef logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-3:0] tag_t;

    // One data word split into byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } word_view_u;

    // --------------------
    // Lane access helpers
    // --------------------

    // Pick the addressed lane and extend it to a full word
    function automatic word_t lane_read(
        input word_view_u   view,
        input access_size_t size,
        input logic [1:0]   offset,
        input logic         sign_ext
    );
        logic [7:0]  lane_b;
        logic [15:0] lane_h;
        lane_b = view.bytes[offset];
        lane_h = view.halves[offset[1]];
        case (size)
            BYTE:    return {{24{sign_ext & lane_b[7]}}, lane_b};
            HALF:    return {{16{sign_ext & lane_h[15]}}, lane_h};
            default: return view;
        endcase
    endfunction

    // Replace only the addressed lane with the low bits of the store data
    function automatic word_view_u lane_write(
        input word_view_u   view,
        input access_size_t size,
        input logic [1:0]   offset,
        input word_t        wdata
    );
        word_view_u merged;
        merged = view;
        case (size)
            BYTE:    merged.bytes[offset] = wdata[7:0];
            HALF:    merged.halves[offset[1]] = wdata[15:0];
            default: merged = wdata;
        endcase
        return merged;
    endfunction

endpackage

`default_nettype wire

// ==== logic/mem_access_pkg.sv ====
`default_nettype none

`include "dcache_defines.svh"

package mem_access_pkg;

    // --------------------
    // CPU access description
    // --------------------

    // Encoded as the number of bytes moved
    typedef enum logic [2:0] {
        BYTE = 3'd1,
        HALF = 3'd2,
        WORD = 3'd4
    } access_size_t;

    typedef logic [`DCACHE_ADDR_BITS-1:0] addr_t;

    typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// ==== include/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Byte address width seen by the CPU
`define DCACHE_ADDR_BITS 18

// 64 lines of one word each
`define DCACHE_INDEX_BITS 6

// Addresses with this bit set are I/O and never cached
`define DCACHE_UNCACHED_BIT 17

// Backing RAM covers the full byte address space
`define DCACHE_RAM_WORDS (1 << (`DCACHE_ADDR_BITS - 2))

// Cycles from an accepted RAM strobe to its ready pulse
`define DCACHE_RAM_LATENCY 4

`endif
